// File: fx_defs.svh
`ifndef FX_DEFS_SVH
`define FX_DEFS_SVH

//////////////////////////////////////////////////////////////////////
// register bank
//////////////////////////////////////////////////////////////////////

`define FX_NUM_LEVELS 12
`define FX_NUM_ROUTES 6
`define FX_NUM_REGS 18

//////////////////////////////////////////////////////////////////////
// frame geometry
//////////////////////////////////////////////////////////////////////

`define FX_H_ACTIVE 64
`define FX_H_TOTAL 80
`define FX_V_ACTIVE 36
`define FX_V_TOTAL 40
`define FX_HSYNC_START 68
`define FX_HSYNC_LEN 6
`define FX_VSYNC_START 37
`define FX_VSYNC_LEN 2

// lines per bar or swatch row
`define FX_ROW_LINES 2
// bar length is the upper 6 bits of a level
`define FX_BAR_SHIFT 4

`endif

// File: fx_pkg.sv
package fx_pkg;

  typedef logic [9:0] fx_level_t;

  // signal source feeding an effect stage
  typedef enum logic [2:0] {
    route_dry        = 3'd0,
    route_delay      = 3'd1,
    route_reverb     = 3'd2,
    route_filter     = 3'd3,
    route_distortion = 3'd4,
    route_crush      = 3'd5,
    route_mix_a      = 3'd6,
    route_mix_b      = 3'd7
  } fx_route_t;

  typedef struct packed {
    logic [21:0] reserved;
    fx_level_t   value;
  } fx_level_word_t;

  typedef struct packed {
    logic [28:0] reserved;
    fx_route_t   value;
  } fx_route_word_t;

  // one APB data word, seen as a level or as a route
  typedef union packed {
    fx_level_word_t level;
    fx_route_word_t route;
  } fx_reg_word_u;

  // 4 bits each of red, green, blue
  typedef logic [11:0] fx_rgb_t;

  function automatic fx_rgb_t fx_route_color(input fx_route_t route);
    case (route)
      route_dry:        return 12'h888;
      route_delay:      return 12'hf00;
      route_reverb:     return 12'h0f0;
      route_filter:     return 12'h00f;
      route_distortion: return 12'hff0;
      route_crush:      return 12'hf0f;
      route_mix_a:      return 12'h0ff;
      route_mix_b:      return 12'hfff;
      default:          return 12'h000;
    endcase
  endfunction

endpackage

// File: fx_param_if.sv
`timescale 1ns/1ps
`include "fx_defs.svh"

// full set of effect settings, levels and routes together
interface fx_param_if;
  import fx_pkg::*;

  fx_level_t levels [`FX_NUM_LEVELS];
  fx_route_t routes [`FX_NUM_ROUTES];

  modport src (
    output levels,
    output routes
  );

  modport dst (
    input levels,
    input routes
  );

endinterface

// File: fx_apb_regs.sv
`timescale 1ns/1ps
`include "fx_defs.svh"

module fx_apb_regs (
  input  logic        clk,
  input  logic        rst,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [7:0]  paddr,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        pready,
  output logic        pslverr,
  fx_param_if.src     params
);
  import fx_pkg::*;

  fx_level_t level_q [`FX_NUM_LEVELS];
  fx_route_t route_q [`FX_NUM_ROUTES];

  logic [5:0]   reg_idx;
  logic [3:0]   level_sel;
  logic [2:0]   route_sel;
  logic         idx_valid;
  logic         is_level;
  logic         access;
  fx_reg_word_u wr_word;
  fx_reg_word_u rd_word;

  //////////////////////////////////////////////////////////////////////
  // address decode
  //////////////////////////////////////////////////////////////////////

  // word addressed, index * 4
  assign reg_idx   = paddr[7:2];
  assign level_sel = reg_idx[3:0];
  // routes sit right after the levels
  assign route_sel = 3'(reg_idx - 6'(`FX_NUM_LEVELS));
  assign idx_valid = reg_idx < 6'(`FX_NUM_REGS);
  assign is_level  = reg_idx < 6'(`FX_NUM_LEVELS);

  // zero wait states
  assign access  = psel && penable;
  assign pready  = access;
  assign pslverr = access && !idx_valid;

  assign wr_word = pwdata;

  //////////////////////////////////////////////////////////////////////
  // register storage
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `FX_NUM_LEVELS; i++) begin
        level_q[i] <= '0;
      end
      for (int i = 0; i < `FX_NUM_ROUTES; i++) begin
        route_q[i] <= route_dry;
      end
    end else if (access && pwrite && idx_valid) begin
      if (is_level) begin
        level_q[level_sel] <= wr_word.level.value;
      end else begin
        route_q[route_sel] <= wr_word.route.value;
      end
    end
  end

  // readback, reserved bits stay zero
  always_comb begin
    rd_word = '0;
    if (access && !pwrite && idx_valid) begin
      if (is_level) begin
        rd_word.level.value = level_q[level_sel];
      end else begin
        rd_word.route.value = route_q[route_sel];
      end
    end
  end

  assign prdata = rd_word;

  assign params.levels = level_q;
  assign params.routes = route_q;

endmodule

// File: clk_cross_buffer.sv
`timescale 1ns/1ps
`include "fx_defs.svh"

module clk_cross_buffer (
  input  logic    clk_pixel,
  input  logic    rst,
  input  logic    new_frame,
  fx_param_if.dst ctl,
  fx_param_if.src pix
);
  import fx_pkg::*;

  fx_level_t level_s1 [`FX_NUM_LEVELS];
  fx_level_t level_s2 [`FX_NUM_LEVELS];
  fx_level_t level_q  [`FX_NUM_LEVELS];
  fx_route_t route_s1 [`FX_NUM_ROUTES];
  fx_route_t route_s2 [`FX_NUM_ROUTES];
  fx_route_t route_q  [`FX_NUM_ROUTES];

  // two flop pipe into the pixel domain
  always_ff @(posedge clk_pixel) begin
    for (int i = 0; i < `FX_NUM_LEVELS; i++) begin
      level_s1[i] <= ctl.levels[i];
      level_s2[i] <= level_s1[i];
    end
    for (int i = 0; i < `FX_NUM_ROUTES; i++) begin
      route_s1[i] <= ctl.routes[i];
      route_s2[i] <= route_s1[i];
    end
  end

  // whole set swaps at once so a frame never mixes old and new
  always_ff @(posedge clk_pixel) begin
    if (rst) begin
      for (int i = 0; i < `FX_NUM_LEVELS; i++) begin
        level_q[i] <= '0;
      end
      for (int i = 0; i < `FX_NUM_ROUTES; i++) begin
        route_q[i] <= route_dry;
      end
    end else if (new_frame) begin
      level_q <= level_s2;
      route_q <= route_s2;
    end
  end

  assign pix.levels = level_q;
  assign pix.routes = route_q;

endmodule

// File: video_timing.sv
`timescale 1ns/1ps
`include "fx_defs.svh"

module video_timing (
  input  logic       clk_pixel,
  input  logic       rst,
  output logic [6:0] hcount,
  output logic [5:0] vcount,
  output logic       hsync,
  output logic       vsync,
  output logic       de,
  output logic       new_frame
);

  logic h_last;
  logic v_last;

  assign h_last = hcount == 7'(`FX_H_TOTAL - 1);
  assign v_last = vcount == 6'(`FX_V_TOTAL - 1);

  //////////////////////////////////////////////////////////////////////
  // raster counters
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_pixel) begin
    if (rst) begin
      hcount <= '0;
      vcount <= '0;
    end else if (h_last) begin
      hcount <= '0;
      if (v_last) begin
        vcount <= '0;
      end else begin
        vcount <= vcount + 6'd1;
      end
    end else begin
      hcount <= hcount + 7'd1;
    end
  end

  // syncs active high inside their windows
  assign hsync = (hcount >= 7'(`FX_HSYNC_START)) &&
                 (hcount < 7'(`FX_HSYNC_START + `FX_HSYNC_LEN));
  assign vsync = (vcount >= 6'(`FX_VSYNC_START)) &&
                 (vcount < 6'(`FX_VSYNC_START + `FX_VSYNC_LEN));

  assign de = (hcount < 7'(`FX_H_ACTIVE)) && (vcount < 6'(`FX_V_ACTIVE));

  // first pixel of vertical blank
  assign new_frame = (hcount == 7'd0) && (vcount == 6'(`FX_V_ACTIVE));

endmodule

// File: param_overlay.sv
`timescale 1ns/1ps
`include "fx_defs.svh"

module param_overlay (
  input  logic            clk_pixel,
  input  logic            rst,
  input  logic [6:0]      hcount,
  input  logic [5:0]      vcount,
  input  logic            hsync_in,
  input  logic            vsync_in,
  input  logic            de_in,
  fx_param_if.dst         params,
  output fx_pkg::fx_rgb_t rgb,
  output logic            hsync,
  output logic            vsync,
  output logic            de
);
  import fx_pkg::*;

  logic [5:0] row;
  logic [3:0] level_sel;
  logic [2:0] route_sel;
  logic [5:0] bar_len;
  fx_rgb_t    pixel_d;

  //////////////////////////////////////////////////////////////////////
  // row decode
  //////////////////////////////////////////////////////////////////////

  assign row       = vcount / 6'(`FX_ROW_LINES);
  assign level_sel = row[3:0];
  assign route_sel = 3'(row - 6'(`FX_NUM_LEVELS));

  // bars on top, route swatches below
  always_comb begin
    bar_len = '0;
    pixel_d = 12'h000;
    if (de_in) begin
      if (row < 6'(`FX_NUM_LEVELS)) begin
        bar_len = 6'(params.levels[level_sel] >> `FX_BAR_SHIFT);
        if (hcount < {1'b0, bar_len}) begin
          pixel_d = 12'hfff;
        end
      end else if (row < 6'(`FX_NUM_REGS)) begin
        pixel_d = fx_route_color(params.routes[route_sel]);
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // output stage
  //////////////////////////////////////////////////////////////////////

  // syncs delayed one cycle to stay lined up with rgb
  always_ff @(posedge clk_pixel) begin
    if (rst) begin
      rgb   <= '0;
      hsync <= 1'b0;
      vsync <= 1'b0;
      de    <= 1'b0;
    end else begin
      rgb   <= pixel_d;
      hsync <= hsync_in;
      vsync <= vsync_in;
      de    <= de_in;
    end
  end

endmodule

// File: fx_panel_top.sv
`timescale 1ns/1ps

module fx_panel_top (
  input  logic            clk,
  input  logic            clk_pixel,
  input  logic            rst,
  input  logic            psel,
  input  logic            penable,
  input  logic            pwrite,
  input  logic [7:0]      paddr,
  input  logic [31:0]     pwdata,
  output logic [31:0]     prdata,
  output logic            pready,
  output logic            pslverr,
  output fx_pkg::fx_rgb_t rgb,
  output logic            hsync,
  output logic            vsync,
  output logic            de
);

  logic [6:0] hcount;
  logic [5:0] vcount;
  logic       hsync_raw;
  logic       vsync_raw;
  logic       de_raw;
  logic       new_frame;

  // settings on clk, and the same settings frame-latched on clk_pixel
  fx_param_if ctl_params ();
  fx_param_if pix_params ();

  fx_apb_regs u_fx_apb_regs (
    .clk     (clk),
    .rst     (rst),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .params  (ctl_params.src)
  );

  clk_cross_buffer u_clk_cross_buffer (
    .clk_pixel (clk_pixel),
    .rst       (rst),
    .new_frame (new_frame),
    .ctl       (ctl_params.dst),
    .pix       (pix_params.src)
  );

  video_timing u_video_timing (
    .clk_pixel (clk_pixel),
    .rst       (rst),
    .hcount    (hcount),
    .vcount    (vcount),
    .hsync     (hsync_raw),
    .vsync     (vsync_raw),
    .de        (de_raw),
    .new_frame (new_frame)
  );

  param_overlay u_param_overlay (
    .clk_pixel (clk_pixel),
    .rst       (rst),
    .hcount    (hcount),
    .vcount    (vcount),
    .hsync_in  (hsync_raw),
    .vsync_in  (vsync_raw),
    .de_in     (de_raw),
    .params    (pix_params.dst),
    .rgb       (rgb),
    .hsync     (hsync),
    .vsync     (vsync),
    .de        (de)
  );

endmodule

// File: tb_fx_panel.sv
`timescale 1ns/1ps
`include "fx_defs.svh"

module tb_fx_panel;
  import fx_pkg::*;

  localparam int FRAME_NS   = `FX_H_TOTAL * `FX_V_TOTAL * 20;
  localparam int LIMIT_NS   = 12 * FRAME_NS + 20000;
  // a few pixels past the frame latch and well before vsync
  localparam int WINDOW_COL = 8;

  logic        clk = 1'b0;
  logic        clk_pixel = 1'b0;
  logic        rst;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [7:0]  paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;
  fx_rgb_t     rgb;
  logic        hsync;
  logic        vsync;
  logic        de;

  int seed        = 25;
  int write_seq   = 0;
  int seen_seq    = 0;
  int applied_seq = 0;
  int h_pos       = 0;
  int v_pos       = 0;
  bit synced      = 1'b0;
  bit vsync_prev  = 1'b0;

  fx_level_t shadow_levels [`FX_NUM_LEVELS] = '{default: '0};
  fx_route_t shadow_routes [`FX_NUM_ROUTES] = '{default: route_dry};
  fx_level_t vis_levels [`FX_NUM_LEVELS]    = '{default: '0};
  fx_route_t vis_routes [`FX_NUM_ROUTES]    = '{default: route_dry};
  // swatch colour per route code
  fx_rgb_t   swatch_colors [8] = '{12'h888, 12'hf00, 12'h0f0, 12'h00f,
                                   12'hff0, 12'hf0f, 12'h0ff, 12'hfff};

  always #10 clk_pixel = ~clk_pixel;
  always #7 clk = ~clk;

  fx_panel_top u_fx_panel_top (
    .clk       (clk),
    .clk_pixel (clk_pixel),
    .rst       (rst),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pready    (pready),
    .pslverr   (pslverr),
    .rgb       (rgb),
    .hsync     (hsync),
    .vsync     (vsync),
    .de        (de)
  );

  //////////////////////////////////////////////////////////////////////
  // reference model and compare tasks
  //////////////////////////////////////////////////////////////////////

  function automatic fx_rgb_t pixel_ref(input int col, input int line);
    int      row;
    fx_rgb_t pix;
    row = line / `FX_ROW_LINES;
    pix = 12'h000;
    if (col < `FX_H_ACTIVE && line < `FX_V_ACTIVE) begin
      if (row < `FX_NUM_LEVELS) begin
        // bar length is level[9:4]
        if (col < int'(vis_levels[row][9:4])) begin
          pix = 12'hfff;
        end
      end else if (row < `FX_NUM_REGS) begin
        pix = swatch_colors[int'(vis_routes[row - `FX_NUM_LEVELS])];
      end
    end
    return pix;
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    $display("** Error at time %0t: %s expected %0h, got %0h", $time, name, expected, actual);
    $display("Errors found");
    $fatal(1, "stopped at the first mismatch");
  endtask

  task automatic check_rgb(input fx_rgb_t expected, input fx_rgb_t actual);
    if (actual !== expected) begin
      report_mismatch($sformatf("rgb (column %0d, line %0d)", h_pos, v_pos),
                      32'(expected), 32'(actual));
    end
  endtask

  task automatic check_prdata(input fx_reg_word_u expected, input fx_reg_word_u actual);
    if (actual !== expected) begin
      report_mismatch("prdata", expected, actual);
    end
  endtask

  task automatic check_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      report_mismatch(name, 32'(expected), 32'(actual));
    end
  endtask

  // follow the raster from the DUT ports and compare every pixel
  always @(negedge clk_pixel) begin
    if (vsync && !vsync_prev) begin
      h_pos = 0;
      v_pos = `FX_VSYNC_START;
      synced = 1'b1;
      // first rise after a write batch arms the update and the second applies it
      if (write_seq != seen_seq) begin
        seen_seq = write_seq;
      end else if (applied_seq != seen_seq) begin
        vis_levels = shadow_levels;
        vis_routes = shadow_routes;
        applied_seq = seen_seq;
      end
    end else if (synced) begin
      if (h_pos == `FX_H_TOTAL - 1) begin
        h_pos = 0;
        v_pos = (v_pos == `FX_V_TOTAL - 1) ? 0 : v_pos + 1;
      end else begin
        h_pos = h_pos + 1;
      end
    end
    vsync_prev = vsync;
    if (synced) begin
      check_flag("de", h_pos < `FX_H_ACTIVE && v_pos < `FX_V_ACTIVE, de);
      check_flag("hsync", h_pos >= `FX_HSYNC_START &&
                 h_pos < `FX_HSYNC_START + `FX_HSYNC_LEN, hsync);
      check_flag("vsync", v_pos >= `FX_VSYNC_START &&
                 v_pos < `FX_VSYNC_START + `FX_VSYNC_LEN, vsync);
      check_rgb(pixel_ref(h_pos, v_pos), rgb);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // APB driver
  //////////////////////////////////////////////////////////////////////

  task automatic apb_transfer(input int idx, input logic write, input logic [31:0] wdata,
                              output logic [31:0] rdata);
    @(negedge clk);
    psel = 1'b1;
    penable = 1'b0;
    pwrite = write;
    paddr = 8'(idx * 4);
    pwdata = wdata;
    @(negedge clk);
    penable = 1'b1;
    // access phase ends at this rising edge
    @(posedge clk);
    check_flag("pready", 1'b1, pready);
    check_flag("pslverr", idx >= `FX_NUM_REGS, pslverr);
    rdata = prdata;
    @(negedge clk);
    psel = 1'b0;
    penable = 1'b0;
  endtask

  task automatic apb_write(input int idx, input logic [31:0] data);
    fx_reg_word_u word;
    logic [31:0]  rd_ignored;
    word = data;
    apb_transfer(idx, 1'b1, data, rd_ignored);
    if (idx < `FX_NUM_LEVELS) begin
      shadow_levels[idx] = word.level.value;
      write_seq++;
    end else if (idx < `FX_NUM_REGS) begin
      shadow_routes[idx - `FX_NUM_LEVELS] = word.route.value;
      write_seq++;
    end
  endtask

  task automatic apb_read_check(input int idx);
    fx_reg_word_u expected;
    logic [31:0]  rdata;
    expected = '0;
    if (idx < `FX_NUM_LEVELS) begin
      expected.level.value = shadow_levels[idx];
    end else if (idx < `FX_NUM_REGS) begin
      expected.route.value = shadow_routes[idx - `FX_NUM_LEVELS];
    end
    apb_transfer(idx, 1'b0, 32'd0, rdata);
    check_prdata(expected, rdata);
  endtask

  // wait for vertical blank just after the frame latch
  task automatic wait_write_window();
    do begin
      @(posedge clk_pixel);
    end while (!(synced && v_pos == `FX_V_ACTIVE && h_pos == WINDOW_COL));
  endtask

  //////////////////////////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////////////////////////

  initial begin
    int bad_idx;
    rst = 1'b1;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = 8'd0;
    pwdata = 32'd0;
    repeat (3) @(negedge clk_pixel);
    check_rgb(12'h000, rgb);
    check_flag("hsync", 1'b0, hsync);
    check_flag("vsync", 1'b0, vsync);
    check_flag("de", 1'b0, de);
    check_flag("pready", 1'b0, pready);
    check_flag("pslverr", 1'b0, pslverr);
    rst = 1'b0;

    // one black frame before the random bars
    wait_write_window();
    for (int i = 0; i < `FX_NUM_LEVELS; i++) begin
      apb_write(i, $random(seed));
      apb_read_check(i);
    end
    wait (applied_seq == write_seq);

    // route swatches
    wait_write_window();
    for (int i = `FX_NUM_LEVELS; i < `FX_NUM_REGS; i++) begin
      apb_write(i, $random(seed));
      apb_read_check(i);
    end
    wait (applied_seq == write_seq);

    // out of range indexes leave the frame alone
    wait_write_window();
    repeat (3) begin
      bad_idx = `FX_NUM_REGS + ($unsigned($random(seed)) % (64 - `FX_NUM_REGS));
      apb_write(bad_idx, $random(seed));
      apb_read_check(bad_idx);
    end

    // the frame already latched keeps the old set
    wait_write_window();
    apb_write(0, $random(seed));
    apb_write(7, $random(seed));
    apb_write(15, $random(seed));
    wait (applied_seq == write_seq);
    wait_write_window();

    $display("No errors");
    $finish;
  end

  // long enough for all the frames the stimulus walks through
  initial begin
    #(LIMIT_NS);
    $display("Test did not finish within %0d ns", LIMIT_NS);
    $display("Errors found");
    $fatal(1, "watchdog timeout");
  end

endmodule

// File: list.f
+incdir+.
fx_pkg.sv
fx_param_if.sv
fx_apb_regs.sv
clk_cross_buffer.sv
video_timing.sv
param_overlay.sv
fx_panel_top.sv
tb_fx_panel.sv

// File: run_sim.sh
#!/bin/sh
# build and run the fx panel testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -f list.f \
  --top-module tb_fx_panel -o sim_fx_panel
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_fx_panel > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

if grep -qx "No errors" sim.log; then
  echo "simulation passed"
  exit 0
fi
echo "simulation failed"
exit 1
